//--- Makefile
SIM = obj_dir/Vtb_nf_datapath

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard rtl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -f src.f --top-module tb_nf_datapath

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_nf_datapath.sv
// ------------------------------------------------
// nf datapath testbench
// random packets on both rx ports with credits,
// reference model per source and destination,
// credit checks and statistics readback
// ------------------------------------------------
`timescale 1ns/1ps

module tb_nf_datapath;

  localparam int QUEUE_DEPTH   = 8;
  localparam int TX_CREDITS    = 4;
  localparam int PKTS_PER_PORT = 40;
  localparam int MAX_BEATS     = 6;
  localparam int HOLD_CYCLES   = 200;
  localparam int RESUME_LIMIT  = 100;
  localparam int SEED          = 37196;
  // 80 packets x 6 beats x stall factor 4 plus margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int NP = nf_pkg::NUM_PORTS;

  // {last, user, data}
  typedef logic [72:0] beat_t;

  logic              core_clk = 1'b0;
  logic              arst_n;
  logic              src_valid [NP];
  nf_pkg::data_t     src_data [NP];
  nf_pkg::user_t     src_user [NP];
  logic              src_last [NP];
  logic              rx_credit [NP];
  logic              tx_valid [NP];
  nf_pkg::data_t     tx_data [NP];
  nf_pkg::user_t     tx_user [NP];
  logic              tx_last [NP];
  logic              sink_credit [NP];
  logic              reg_rd_en;
  nf_pkg::reg_addr_t reg_rd_addr;
  logic              reg_rd_valid;
  nf_pkg::reg_data_t reg_rd_data;

  // expected beats indexed by src * NP + dst
  beat_t exp_q [NP*NP][$];

  // source side state
  int src_crd [NP];
  int beats_left [NP];
  int cur_dst [NP];
  int pkts_sent [NP];
  int dst_pkts [NP];
  // sink side state
  int out_cnt [NP];
  bit in_pkt [NP];
  int cur_src [NP];
  int tx_beats [NP];
  int hold_beats [NP];
  bit hold_credits;

  int value_errs;
  int proto_errs;
  int cycle_cnt = 0;

  always #20 core_clk = ~core_clk;

  nf_datapath_top dut_i (
    .core_clk     (core_clk),       .arst_n      (arst_n),
    .rx0_valid    (src_valid[0]),   .rx0_data    (src_data[0]),
    .rx0_user     (src_user[0]),    .rx0_last    (src_last[0]),
    .rx0_credit   (rx_credit[0]),
    .rx1_valid    (src_valid[1]),   .rx1_data    (src_data[1]),
    .rx1_user     (src_user[1]),    .rx1_last    (src_last[1]),
    .rx1_credit   (rx_credit[1]),
    .tx0_valid    (tx_valid[0]),    .tx0_data    (tx_data[0]),
    .tx0_user     (tx_user[0]),     .tx0_last    (tx_last[0]),
    .tx0_credit   (sink_credit[0]),
    .tx1_valid    (tx_valid[1]),    .tx1_data    (tx_data[1]),
    .tx1_user     (tx_user[1]),     .tx1_last    (tx_last[1]),
    .tx1_credit   (sink_credit[1]),
    .reg_rd_en    (reg_rd_en),      .reg_rd_addr (reg_rd_addr),
    .reg_rd_valid (reg_rd_valid),   .reg_rd_data (reg_rd_data)
  );

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic check_reset_outputs();
    for (int p = 0; p < NP; p++) begin
      check_value($sformatf("tx%0d_valid", p), 64'(tx_valid[p]), 64'd0);
      check_value($sformatf("rx%0d_credit", p), 64'(rx_credit[p]), 64'd0);
    end
    check_value("reg_rd_valid", 64'(reg_rd_valid), 64'd0);
  endtask

  // one beat from source p
  // model entry carries the arbiter's source tag
  task automatic send_beat(input int p);
    nf_pkg::user_t user;
    if (beats_left[p] == 0) begin
      beats_left[p] = $urandom_range(MAX_BEATS, 1);
      cur_dst[p] = $urandom_range(1);
      dst_pkts[cur_dst[p]]++;
    end
    user = nf_pkg::user_t'($urandom);
    user[nf_pkg::DST_BIT] = cur_dst[p][0];
    src_valid[p] = 1'b1;
    src_data[p] = {$urandom, $urandom};
    src_user[p] = user;
    src_last[p] = (beats_left[p] == 1);
    src_crd[p]--;
    beats_left[p]--;
    if (src_last[p]) begin
      pkts_sent[p]++;
    end
    user[nf_pkg::SRC_BIT] = p[0];
    exp_q[p*NP + cur_dst[p]].push_back({src_last[p], user, src_data[p]});
  endtask

  task automatic source_loop();
    forever begin
      @(negedge core_clk);
      for (int p = 0; p < NP; p++) begin
        if (rx_credit[p]) begin
          src_crd[p]++;
        end
        assert (src_crd[p] <= QUEUE_DEPTH) else begin
          proto_errs++;
          $display("ERROR t=%0t rx%0d returned more credits than the queue holds", $time, p);
        end
        src_valid[p] = 1'b0;
        // random idle cycles
        if (src_crd[p] > 0 && pkts_sent[p] < PKTS_PER_PORT && $urandom_range(3) != 0) begin
          send_beat(p);
        end
      end
    end
  endtask

  // compare one egress beat on port p with the model
  task automatic check_beat(input int p);
    beat_t exp;
    int    idx;
    assert (out_cnt[p] < TX_CREDITS) else begin
      proto_errs++;
      $display("ERROR t=%0t tx%0d sent a beat with no sink credit left", $time, p);
    end
    out_cnt[p]++;
    tx_beats[p]++;
    if (hold_credits) begin
      hold_beats[p]++;
    end
    if (!in_pkt[p]) begin
      // first beat names this port and its source
      check_value($sformatf("tx%0d_user[DST_BIT]", p),
                  64'(tx_user[p][nf_pkg::DST_BIT]), 64'(p));
      cur_src[p] = int'(tx_user[p][nf_pkg::SRC_BIT]);
    end else begin
      assert (tx_user[p][nf_pkg::SRC_BIT] == cur_src[p][0]) else begin
        proto_errs++;
        $display("ERROR t=%0t tx%0d mixed beats of two packets", $time, p);
      end
    end
    idx = cur_src[p]*NP + p;
    assert (exp_q[idx].size() > 0) else begin
      proto_errs++;
      $display("ERROR t=%0t tx%0d sent a beat nobody expected", $time, p);
    end
    if (exp_q[idx].size() > 0) begin
      exp = exp_q[idx].pop_front();
      check_value($sformatf("tx%0d_data", p), tx_data[p], exp[63:0]);
      check_value($sformatf("tx%0d_user", p), 64'(tx_user[p]), 64'(exp[71:64]));
      check_value($sformatf("tx%0d_last", p), 64'(tx_last[p]), 64'(exp[72]));
    end
    in_pkt[p] = !tx_last[p];
  endtask

  task automatic sink_loop();
    forever begin
      @(negedge core_clk);
      for (int p = 0; p < NP; p++) begin
        sink_credit[p] = 1'b0;
        if (tx_valid[p]) begin
          check_beat(p);
        end
        // random credit return delay
        if (!hold_credits && out_cnt[p] > 0 && $urandom_range(3) != 0) begin
          sink_credit[p] = 1'b1;
          out_cnt[p]--;
        end
      end
    end
  endtask

  function automatic bit all_drained();
    bit done;
    done = 1'b1;
    for (int p = 0; p < NP; p++) begin
      if (pkts_sent[p] != PKTS_PER_PORT) begin
        done = 1'b0;
      end
    end
    for (int i = 0; i < NP*NP; i++) begin
      if (exp_q[i].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  function automatic logic [63:0] expected_reg(input int addr);
    case (addr)
      0: return 64'(pkts_sent[0]);
      1: return 64'(pkts_sent[1]);
      2: return 64'(dst_pkts[0]);
      3: return 64'(dst_pkts[1]);
      default: return 64'd0;
    endcase
  endfunction

  task automatic read_reg(input int addr);
    @(negedge core_clk);
    reg_rd_en = 1'b1;
    reg_rd_addr = nf_pkg::reg_addr_t'(addr);
    @(negedge core_clk);
    reg_rd_en = 1'b0;
    check_value("reg_rd_valid", 64'(reg_rd_valid), 64'd1);
    check_value($sformatf("reg_rd_data[%0d]", addr), 64'(reg_rd_data), expected_reg(addr));
    // valid is a single cycle
    @(negedge core_clk);
    check_value("reg_rd_valid", 64'(reg_rd_valid), 64'd0);
  endtask

  // ------------------------------------------------
  // run limit
  // ------------------------------------------------
  always @(posedge core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR run hung, traffic not finished after %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    int seen;
    int waited;
    void'($urandom(SEED));
    arst_n = 1'b0;
    reg_rd_en = 1'b0;
    reg_rd_addr = '0;
    hold_credits = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    for (int p = 0; p < NP; p++) begin
      src_valid[p] = 1'b0;
      src_data[p] = '0;
      src_user[p] = '0;
      src_last[p] = 1'b0;
      sink_credit[p] = 1'b0;
      src_crd[p] = QUEUE_DEPTH;
      beats_left[p] = 0;
      cur_dst[p] = 0;
      pkts_sent[p] = 0;
      dst_pkts[p] = 0;
      out_cnt[p] = 0;
      in_pkt[p] = 1'b0;
      cur_src[p] = 0;
      tx_beats[p] = 0;
      hold_beats[p] = 0;
    end
    repeat (3) begin
      @(negedge core_clk);
      check_reset_outputs();
    end
    arst_n = 1'b1;
    @(negedge core_clk);
    check_reset_outputs();

    // sink starts with credits held back
    hold_credits = 1'b1;
    fork
      source_loop();
      sink_loop();
    join_none
    repeat (HOLD_CYCLES) @(posedge core_clk);
    for (int p = 0; p < NP; p++) begin
      assert (hold_beats[p] <= TX_CREDITS) else begin
        proto_errs++;
        $display("ERROR tx%0d sent %0d beats while credits were held", p, hold_beats[p]);
      end
    end
    seen = tx_beats[0] + tx_beats[1];
    hold_credits = 1'b0;
    waited = 0;
    while (tx_beats[0] + tx_beats[1] == seen && waited < RESUME_LIMIT) begin
      @(posedge core_clk);
      waited++;
    end
    assert (tx_beats[0] + tx_beats[1] != seen) else begin
      proto_errs++;
      $display("ERROR traffic did not resume after sink credits returned");
    end

    // drain and let trailing credits and counters settle
    while (!all_drained()) begin
      @(posedge core_clk);
    end
    repeat (4) @(posedge core_clk);
    for (int p = 0; p < NP; p++) begin
      assert (src_crd[p] == QUEUE_DEPTH) else begin
        proto_errs++;
        $display("ERROR rx%0d source holds %0d credits after the drain", p, src_crd[p]);
      end
    end
    for (int a = 0; a < 8; a++) begin
      read_reg(a);
    end

    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- rtl/input_arbiter.sv
// ------------------------------------------------
// input arbiter
// packet-granular round robin over the rx queues,
// drives the shared bus and tags the source port
// ------------------------------------------------
`timescale 1ns/1ps

module input_arbiter (
  input  logic                                 core_clk,
  input  logic                                 arst_n,
  input  logic          [nf_pkg::NUM_PORTS-1:0] q_valid,
  input  nf_pkg::data_t [nf_pkg::NUM_PORTS-1:0] q_data,
  input  nf_pkg::user_t [nf_pkg::NUM_PORTS-1:0] q_user,
  input  logic          [nf_pkg::NUM_PORTS-1:0] q_last,
  input  logic                                 bus_ready,
  output logic          [nf_pkg::NUM_PORTS-1:0] q_pop,
  output logic                                 bus_valid,
  output nf_pkg::data_t                        bus_data,
  output nf_pkg::user_t                        bus_user,
  output logic                                 bus_last
);

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

  arb_state_t       state;
  nf_pkg::port_id_t grant;
  // port that wins when both are waiting in idle
  nf_pkg::port_id_t rr_ptr;
  logic             xfer;

  // ------------------------------------------------
  // bus mux
  // ------------------------------------------------
  always_comb begin
    bus_valid = (state == ARB_BUSY) && q_valid[grant];
    bus_data  = q_data[grant];
    bus_last  = q_last[grant];
    bus_user  = q_user[grant];
    // source tag replaces whatever the sender put there
    bus_user[nf_pkg::SRC_BIT] = grant;
    xfer  = bus_valid && bus_ready;
    q_pop = '0;
    q_pop[grant] = xfer;
  end

  // ------------------------------------------------
  // grant fsm
  // ------------------------------------------------
  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= ARB_IDLE;
      grant  <= '0;
      rr_ptr <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (q_valid[rr_ptr]) begin
            grant <= rr_ptr;
            state <= ARB_BUSY;
          end else if (q_valid[~rr_ptr]) begin
            grant <= ~rr_ptr;
            state <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // grant only moves at a packet boundary
          if (xfer && bus_last) begin
            rr_ptr <= ~grant;
            if (q_valid[~grant]) begin
              // other port waiting, hand over directly
              grant <= ~grant;
            end else begin
              state <= ARB_IDLE;
            end
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/nf_datapath_top.sv
// ------------------------------------------------
// nf datapath top
// two rx queues, round robin arbiter, output port
// lookup, two tx queues and packet statistics
// ------------------------------------------------
`timescale 1ns/1ps

module nf_datapath_top #(
  parameter int QUEUE_DEPTH = 8,
  parameter int TX_CREDITS  = 4
) (
  input  logic              core_clk,
  input  logic              arst_n,
  // receive port 0
  input  logic              rx0_valid,
  input  nf_pkg::data_t     rx0_data,
  input  nf_pkg::user_t     rx0_user,
  input  logic              rx0_last,
  output logic              rx0_credit,
  // receive port 1
  input  logic              rx1_valid,
  input  nf_pkg::data_t     rx1_data,
  input  nf_pkg::user_t     rx1_user,
  input  logic              rx1_last,
  output logic              rx1_credit,
  // transmit port 0
  output logic              tx0_valid,
  output nf_pkg::data_t     tx0_data,
  output nf_pkg::user_t     tx0_user,
  output logic              tx0_last,
  input  logic              tx0_credit,
  // transmit port 1
  output logic              tx1_valid,
  output nf_pkg::data_t     tx1_data,
  output nf_pkg::user_t     tx1_user,
  output logic              tx1_last,
  input  logic              tx1_credit,
  // statistics read port
  input  logic              reg_rd_en,
  input  nf_pkg::reg_addr_t reg_rd_addr,
  output logic              reg_rd_valid,
  output nf_pkg::reg_data_t reg_rd_data
);

  // ------------------------------------------------
  // internal nets
  // ------------------------------------------------
  // rx queue heads
  logic          [nf_pkg::NUM_PORTS-1:0] q_valid;
  nf_pkg::data_t [nf_pkg::NUM_PORTS-1:0] q_data;
  nf_pkg::user_t [nf_pkg::NUM_PORTS-1:0] q_user;
  logic          [nf_pkg::NUM_PORTS-1:0] q_last;
  logic          [nf_pkg::NUM_PORTS-1:0] q_pop;
  // shared bus
  logic                                  bus_valid;
  logic                                  bus_ready;
  nf_pkg::data_t                         bus_data;
  nf_pkg::user_t                         bus_user;
  logic                                  bus_last;
  // lookup to tx queues
  logic          [nf_pkg::NUM_PORTS-1:0] wr_en;
  logic          [nf_pkg::NUM_PORTS-1:0] wr_space;
  nf_pkg::data_t                         wr_data;
  nf_pkg::user_t                         wr_user;
  logic                                  wr_last;
  // statistics events
  logic          [nf_pkg::NUM_PORTS-1:0] rx_pkt_done;
  logic          [nf_pkg::NUM_PORTS-1:0] tx_pkt_done;

  // ------------------------------------------------
  // ingress
  // ------------------------------------------------
  rx_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) rx0_queue_i (
    .core_clk (core_clk),       .arst_n  (arst_n),
    .in_valid (rx0_valid),      .in_data (rx0_data),
    .in_user  (rx0_user),       .in_last (rx0_last),
    .q_pop    (q_pop[0]),       .credit  (rx0_credit),
    .q_valid  (q_valid[0]),     .q_data  (q_data[0]),
    .q_user   (q_user[0]),      .q_last  (q_last[0]),
    .pkt_done (rx_pkt_done[0])
  );

  rx_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) rx1_queue_i (
    .core_clk (core_clk),       .arst_n  (arst_n),
    .in_valid (rx1_valid),      .in_data (rx1_data),
    .in_user  (rx1_user),       .in_last (rx1_last),
    .q_pop    (q_pop[1]),       .credit  (rx1_credit),
    .q_valid  (q_valid[1]),     .q_data  (q_data[1]),
    .q_user   (q_user[1]),      .q_last  (q_last[1]),
    .pkt_done (rx_pkt_done[1])
  );

  input_arbiter input_arbiter_i (
    .core_clk  (core_clk),  .arst_n    (arst_n),
    .q_valid   (q_valid),   .q_data    (q_data),
    .q_user    (q_user),    .q_last    (q_last),
    .bus_ready (bus_ready), .q_pop     (q_pop),
    .bus_valid (bus_valid), .bus_data  (bus_data),
    .bus_user  (bus_user),  .bus_last  (bus_last)
  );

  // ------------------------------------------------
  // egress
  // ------------------------------------------------
  output_port_lookup output_port_lookup_i (
    .core_clk  (core_clk),  .arst_n    (arst_n),
    .bus_valid (bus_valid), .bus_data  (bus_data),
    .bus_user  (bus_user),  .bus_last  (bus_last),
    .wr_space  (wr_space),  .bus_ready (bus_ready),
    .wr_en     (wr_en),     .wr_data   (wr_data),
    .wr_user   (wr_user),   .wr_last   (wr_last)
  );

  tx_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .TX_CREDITS(TX_CREDITS)) tx0_queue_i (
    .core_clk  (core_clk),    .arst_n    (arst_n),
    .wr_en     (wr_en[0]),    .wr_data   (wr_data),
    .wr_user   (wr_user),     .wr_last   (wr_last),
    .credit    (tx0_credit),  .wr_space  (wr_space[0]),
    .out_valid (tx0_valid),   .out_data  (tx0_data),
    .out_user  (tx0_user),    .out_last  (tx0_last),
    .pkt_done  (tx_pkt_done[0])
  );

  tx_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .TX_CREDITS(TX_CREDITS)) tx1_queue_i (
    .core_clk  (core_clk),    .arst_n    (arst_n),
    .wr_en     (wr_en[1]),    .wr_data   (wr_data),
    .wr_user   (wr_user),     .wr_last   (wr_last),
    .credit    (tx1_credit),  .wr_space  (wr_space[1]),
    .out_valid (tx1_valid),   .out_data  (tx1_data),
    .out_user  (tx1_user),    .out_last  (tx1_last),
    .pkt_done  (tx_pkt_done[1])
  );

  // ------------------------------------------------
  // statistics
  // ------------------------------------------------
  stats_regs stats_regs_i (
    .core_clk     (core_clk),     .arst_n       (arst_n),
    .rx_pkt_done  (rx_pkt_done),  .tx_pkt_done  (tx_pkt_done),
    .reg_rd_en    (reg_rd_en),    .reg_rd_addr  (reg_rd_addr),
    .reg_rd_valid (reg_rd_valid), .reg_rd_data  (reg_rd_data)
  );

endmodule

//--- rtl/nf_pkg.sv
// ------------------------------------------------
// nf datapath shared definitions
// beat widths, user sideband layout and the
// statistics register map
// ------------------------------------------------

package nf_pkg;

  // ------------------------------------------------
  // stream beat
  // ------------------------------------------------
  // one beat of packet data
  typedef logic [63:0] data_t;
  // per-beat user sideband
  typedef logic [7:0]  user_t;

  // destination port bit, set by the source
  localparam int DST_BIT = 0;
  // source port bit, overwritten by the arbiter
  localparam int SRC_BIT = 4;

  // ------------------------------------------------
  // ports
  // ------------------------------------------------
  localparam int NUM_PORTS = 2;
  typedef logic [0:0] port_id_t;

  // ------------------------------------------------
  // statistics registers, read only
  // ------------------------------------------------
  typedef logic [2:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  localparam reg_addr_t REG_RX0_PKTS = 3'd0;
  localparam reg_addr_t REG_RX1_PKTS = 3'd1;
  localparam reg_addr_t REG_TX0_PKTS = 3'd2;
  localparam reg_addr_t REG_TX1_PKTS = 3'd3;

endpackage

//--- rtl/output_port_lookup.sv
// ------------------------------------------------
// output port lookup
// steers whole packets from the shared bus to the
// tx queue named by the destination bit
// ------------------------------------------------
`timescale 1ns/1ps

module output_port_lookup (
  input  logic                        core_clk,
  input  logic                        arst_n,
  input  logic                        bus_valid,
  input  nf_pkg::data_t               bus_data,
  input  nf_pkg::user_t               bus_user,
  input  logic                        bus_last,
  input  logic [nf_pkg::NUM_PORTS-1:0] wr_space,
  output logic                        bus_ready,
  output logic [nf_pkg::NUM_PORTS-1:0] wr_en,
  output nf_pkg::data_t               wr_data,
  output nf_pkg::user_t               wr_user,
  output logic                        wr_last
);

  typedef enum logic {
    LKP_HEAD,
    LKP_BODY
  } lookup_state_t;

  lookup_state_t    state;
  // target latched from the first beat
  nf_pkg::port_id_t target;
  nf_pkg::port_id_t cur_port;
  logic             xfer;

  // ------------------------------------------------
  // steering, purely combinational
  // ------------------------------------------------
  always_comb begin
    // head beat decodes, body beats follow the latched port
    cur_port = (state == LKP_HEAD) ? bus_user[nf_pkg::DST_BIT] : target;
    // ready tracks only the current target, never splits a packet
    bus_ready = wr_space[cur_port];
    xfer      = bus_valid && bus_ready;
    wr_en     = '0;
    wr_en[cur_port] = xfer;
  end

  // payload shared by both queues, wr_en picks one
  assign wr_data = bus_data;
  assign wr_user = bus_user;
  assign wr_last = bus_last;

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= LKP_HEAD;
      target <= '0;
    end else if (xfer) begin
      if (state == LKP_HEAD) begin
        target <= cur_port;
        // single-beat packet stays in head
        if (!bus_last) begin
          state <= LKP_BODY;
        end
      end else if (bus_last) begin
        state <= LKP_HEAD;
      end
    end
  end

endmodule

//--- rtl/rx_queue.sv
// ------------------------------------------------
// rx queue
// ingress buffer for one receive port that hands
// one credit back to the source per beat popped
// ------------------------------------------------
`timescale 1ns/1ps

module rx_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic          core_clk,
  input  logic          arst_n,
  input  logic          in_valid,
  input  nf_pkg::data_t in_data,
  input  nf_pkg::user_t in_user,
  input  logic          in_last,
  input  logic          q_pop,
  output logic          credit,
  output logic          q_valid,
  output nf_pkg::data_t q_data,
  output nf_pkg::user_t q_user,
  output logic          q_last,
  output logic          pkt_done
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  // packet storage
  nf_pkg::data_t mem_data [QUEUE_DEPTH];
  nf_pkg::user_t mem_user [QUEUE_DEPTH];
  logic          mem_last [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;

  // head of queue visible right after the write edge
  assign q_valid = (fill != '0);
  assign q_data  = mem_data[rd_ptr];
  assign q_user  = mem_user[rd_ptr];
  assign q_last  = mem_last[rd_ptr];

  // the source only sends with a credit in hand
  always_ff @(posedge core_clk) begin
    if (in_valid) begin
      mem_data[wr_ptr] <= in_data;
      mem_user[wr_ptr] <= in_user;
      mem_last[wr_ptr] <= in_last;
    end
  end

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credit   <= 1'b0;
      pkt_done <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + CNT_W'(in_valid) - CNT_W'(q_pop);
      // credit goes back the cycle after the pop
      credit <= q_pop;
      // packet counted when its last beat lands
      pkt_done <= in_valid & in_last;
    end
  end

endmodule

//--- rtl/stats_regs.sv
// ------------------------------------------------
// statistics registers
// per-port packet counters behind a one-cycle
// read port
// ------------------------------------------------
`timescale 1ns/1ps

module stats_regs (
  input  logic                        core_clk,
  input  logic                        arst_n,
  input  logic [nf_pkg::NUM_PORTS-1:0] rx_pkt_done,
  input  logic [nf_pkg::NUM_PORTS-1:0] tx_pkt_done,
  input  logic                        reg_rd_en,
  input  nf_pkg::reg_addr_t           reg_rd_addr,
  output logic                        reg_rd_valid,
  output nf_pkg::reg_data_t           reg_rd_data
);

  // wrapping counters, one per port and direction
  nf_pkg::reg_data_t rx_pkts [nf_pkg::NUM_PORTS];
  nf_pkg::reg_data_t tx_pkts [nf_pkg::NUM_PORTS];

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < nf_pkg::NUM_PORTS; p++) begin
        rx_pkts[p] <= '0;
        tx_pkts[p] <= '0;
      end
      reg_rd_valid <= 1'b0;
    end else begin
      for (int p = 0; p < nf_pkg::NUM_PORTS; p++) begin
        if (rx_pkt_done[p]) begin
          rx_pkts[p] <= rx_pkts[p] + 1'b1;
        end
        if (tx_pkt_done[p]) begin
          tx_pkts[p] <= tx_pkts[p] + 1'b1;
        end
      end
      reg_rd_valid <= reg_rd_en;
    end
  end

  // ------------------------------------------------
  // read data, one cycle after the request
  // ------------------------------------------------
  always_ff @(posedge core_clk) begin
    if (reg_rd_en) begin
      case (reg_rd_addr)
        nf_pkg::REG_RX0_PKTS: reg_rd_data <= rx_pkts[0];
        nf_pkg::REG_RX1_PKTS: reg_rd_data <= rx_pkts[1];
        nf_pkg::REG_TX0_PKTS: reg_rd_data <= tx_pkts[0];
        nf_pkg::REG_TX1_PKTS: reg_rd_data <= tx_pkts[1];
        // unmapped addresses read as zero
        default:              reg_rd_data <= '0;
      endcase
    end
  end

endmodule

//--- rtl/tx_queue.sv
// ------------------------------------------------
// tx queue
// egress buffer for one transmit port, sends only
// while it holds credits from the sink
// ------------------------------------------------
`timescale 1ns/1ps

module tx_queue #(
  parameter int QUEUE_DEPTH = 8,
  parameter int TX_CREDITS  = 4
) (
  input  logic          core_clk,
  input  logic          arst_n,
  input  logic          wr_en,
  input  nf_pkg::data_t wr_data,
  input  nf_pkg::user_t wr_user,
  input  logic          wr_last,
  input  logic          credit,
  output logic          wr_space,
  output logic          out_valid,
  output nf_pkg::data_t out_data,
  output nf_pkg::user_t out_user,
  output logic          out_last,
  output logic          pkt_done
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(TX_CREDITS + 1);

  nf_pkg::data_t mem_data [QUEUE_DEPTH];
  nf_pkg::user_t mem_user [QUEUE_DEPTH];
  logic          mem_last [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  // sink buffer slots we may still fill
  logic [CRD_W-1:0] credits;
  logic             send;

  assign wr_space = (fill != CNT_W'(QUEUE_DEPTH));
  // need a buffered beat and a credit
  assign send     = (fill != '0) && (credits != '0);

  always_ff @(posedge core_clk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= wr_data;
      mem_user[wr_ptr] <= wr_user;
      mem_last[wr_ptr] <= wr_last;
    end
    // registered output beat
    if (send) begin
      out_data <= mem_data[rd_ptr];
      out_user <= mem_user[rd_ptr];
      out_last <= mem_last[rd_ptr];
    end
  end

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= CRD_W'(TX_CREDITS);
      out_valid <= 1'b0;
      pkt_done  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + CNT_W'(wr_en) - CNT_W'(send);
      // spend and refill can land in the same cycle
      credits   <= credits + CRD_W'(credit) - CRD_W'(send);
      out_valid <= send;
      pkt_done  <= send & mem_last[rd_ptr];
    end
  end

endmodule

//--- src.f
rtl/nf_pkg.sv
rtl/rx_queue.sv
rtl/input_arbiter.sv
rtl/output_port_lookup.sv
rtl/tx_queue.sv
rtl/stats_regs.sv
rtl/nf_datapath_top.sv
dv/tb_nf_datapath.sv
